// File: verilog/icache_pkg.sv
`default_nettype none

package icache_pkg;

	localparam int ADDR_WIDTH = 32;
	localparam int WORD_BYTES = 4;
	localparam int NUM_WAYS = 4; // the plru tree below only covers four ways

	typedef logic [31:0] word_t;
	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [1:0] way_t;
	typedef logic [2:0] plru_t; // bit 2 root, bit 1 ways 2/3, bit 0 ways 0/1

	typedef enum logic [2:0] {
		INVALIDATING,
		IDLE,
		MEM_REQUEST,
		RECEIVING,
		LINE_DONE
	} icache_state_e;

	function automatic way_t plru_victim(input plru_t bits);
		if (bits[2])
			return bits[0] ? 2'd0 : 2'd1;
		return bits[1] ? 2'd2 : 2'd3;
	endfunction

	// point root and pair bit away from the accessed way
	function automatic plru_t plru_update(input plru_t bits, input way_t way);
		plru_t upd;
		upd = bits;
		upd[2] = way[1];
		if (way[1])
			upd[1] = way[0];
		else
			upd[0] = way[0];
		return upd;
	endfunction

endpackage

`default_nettype wire

// File: verilog/icache_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array #(
	parameter int SETS = 64,
	parameter int WORDS_PER_LINE = 8,
	localparam int IDX_W = $clog2(SETS),
	localparam int TAG_W = icache_pkg::ADDR_WIDTH - IDX_W - $clog2(WORDS_PER_LINE)
		- $clog2(icache_pkg::WORD_BYTES)
) (
	input  logic                                       i_clk,
	input  logic [IDX_W-1:0]                           i_rd_index,
	input  logic                                       i_wr_en,
	input  icache_pkg::way_t                           i_wr_way,
	input  logic [IDX_W-1:0]                           i_wr_index,
	input  logic                                       i_wr_valid,
	input  logic [TAG_W-1:0]                           i_wr_tag,
	output logic [icache_pkg::NUM_WAYS-1:0]            o_rd_valid,
	output logic [icache_pkg::NUM_WAYS-1:0][TAG_W-1:0] o_rd_tags
);
	import icache_pkg::*;

	logic [NUM_WAYS-1:0] valid_q [SETS];
	logic [TAG_W-1:0] tag_mem [NUM_WAYS][SETS];
	logic [IDX_W-1:0] rd_index_q;
	logic same_set;

	assign same_set = i_wr_en && (i_wr_index == i_rd_index);

	always_ff @(posedge i_clk) begin
		if (i_wr_en) begin
			if (i_wr_valid) begin
				valid_q[i_wr_index][i_wr_way] <= 1'b1;
				tag_mem[i_wr_way][i_wr_index] <= i_wr_tag;
			end else begin
				valid_q[i_wr_index] <= '0; // invalidate drops the whole set
			end
		end
	end

	// replay read in the tag write cycle sees the new line
	always_ff @(posedge i_clk) begin
		rd_index_q <= i_rd_index;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (same_set && !i_wr_valid)
				o_rd_valid[w] <= 1'b0;
			else if (same_set && i_wr_way == way_t'(w))
				o_rd_valid[w] <= 1'b1;
			else
				o_rd_valid[w] <= valid_q[i_rd_index][w];
			if (same_set && i_wr_valid && i_wr_way == way_t'(w))
				o_rd_tags[w] <= i_wr_tag;
			else
				o_rd_tags[w] <= tag_mem[w][i_rd_index];
		end
	end

	// result on the outputs must not go stale under a write unless that set is re-read
	a_no_stale_read: assert property (@(posedge i_clk)
		i_wr_en && (i_wr_index == rd_index_q) |-> i_rd_index == i_wr_index);

endmodule

`default_nettype wire

// File: verilog/icache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_data_array #(
	parameter int SETS = 64,
	parameter int WORDS_PER_LINE = 8,
	localparam int IDX_W = $clog2(SETS),
	localparam int OFF_W = $clog2(WORDS_PER_LINE)
) (
	input  logic                    i_clk,
	input  logic [IDX_W-1:0]        i_rd_index,
	input  logic                    i_wr_en,
	input  icache_pkg::way_t        i_wr_way,
	input  logic [IDX_W-1:0]        i_wr_index,
	input  logic [OFF_W-1:0]        i_wr_offset,
	input  icache_pkg::word_t       i_wr_data,
	output icache_pkg::word_t [icache_pkg::NUM_WAYS-1:0][WORDS_PER_LINE-1:0] o_rd_lines
);
	import icache_pkg::*;

	word_t line_mem [NUM_WAYS][SETS][WORDS_PER_LINE];

	always_ff @(posedge i_clk) begin
		if (i_wr_en)
			line_mem[i_wr_way][i_wr_index][i_wr_offset] <= i_wr_data; // one refill beat
	end

	// whole set read at once for the word select in the lookup
	always_ff @(posedge i_clk) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			for (int k = 0; k < WORDS_PER_LINE; k++) begin
				o_rd_lines[w][k] <= line_mem[w][i_rd_index][k];
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/icache_plru.sv
`timescale 1ns/1ps
`default_nettype none

module icache_plru #(
	parameter int SETS = 64,
	localparam int IDX_W = $clog2(SETS)
) (
	input  logic             i_clk,
	input  logic             i_rst,
	input  logic             i_access_valid,
	input  logic [IDX_W-1:0] i_access_index,
	input  logic             i_hit,
	input  icache_pkg::way_t i_hit_way,
	output icache_pkg::way_t o_victim_way
);
	import icache_pkg::*;

	plru_t plru_q [SETS];
	plru_t cur_bits;
	way_t touched_way;

	assign cur_bits = plru_q[i_access_index];
	assign o_victim_way = plru_victim(cur_bits);
	assign touched_way = i_hit ? i_hit_way : o_victim_way; // miss claims the victim

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int s = 0; s < SETS; s++) begin
				plru_q[s] <= '0;
			end
		end else if (i_access_valid) begin
			plru_q[i_access_index] <= plru_update(cur_bits, touched_way);
		end
	end

endmodule

`default_nettype wire

// File: verilog/icache_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module icache_lookup #(
	parameter int SETS = 64,
	parameter int WORDS_PER_LINE = 8,
	localparam int IDX_W = $clog2(SETS),
	localparam int OFF_W = $clog2(WORDS_PER_LINE),
	localparam int BYTE_W = $clog2(icache_pkg::WORD_BYTES),
	localparam int TAG_W = icache_pkg::ADDR_WIDTH - IDX_W - OFF_W - BYTE_W
) (
	input  logic                                       i_clk,
	input  logic                                       i_rst,
	input  logic                                       i_req_valid,
	input  icache_pkg::addr_t                          i_req_addr,
	output logic                                       o_req_ready,
	output logic                                       o_rsp_valid,
	output icache_pkg::word_t                          o_rsp_data,
	input  logic                                       i_rsp_ready,
	input  logic                                       i_lookup_enable,
	output logic [IDX_W-1:0]                           o_rd_index,
	input  logic [icache_pkg::NUM_WAYS-1:0]            i_tag_valid,
	input  logic [icache_pkg::NUM_WAYS-1:0][TAG_W-1:0] i_tags,
	input  icache_pkg::word_t [icache_pkg::NUM_WAYS-1:0][WORDS_PER_LINE-1:0] i_lines,
	output logic                                       o_access_valid,
	output logic [IDX_W-1:0]                           o_access_index,
	output logic                                       o_hit,
	output icache_pkg::way_t                           o_hit_way,
	input  icache_pkg::way_t                           i_victim_way,
	output logic                                       o_miss,
	output icache_pkg::addr_t                          o_miss_addr,
	output icache_pkg::way_t                           o_miss_way,
	input  logic                                       i_line_done
);
	import icache_pkg::*;

	logic s1_valid_q;
	addr_t s1_addr_q;
	logic replay_q; // missed address re-read, data on the arrays now
	logic miss_q;
	addr_t miss_addr_q;
	way_t miss_way_q;
	logic rsp_valid_q;
	word_t rsp_data_q;

	addr_t cur_addr;
	addr_t rd_addr;
	logic cur_valid;
	logic [NUM_WAYS-1:0] way_hit;
	logic any_hit;
	way_t hit_way;
	logic [OFF_W-1:0] word_off;
	logic adv;
	logic eval_fire;
	logic miss_now;
	logic s1_done;
	logic req_fire;

	assign cur_addr = replay_q ? miss_addr_q : s1_addr_q;
	assign cur_valid = i_lookup_enable && (replay_q || (s1_valid_q && !miss_q));
	assign word_off = cur_addr[BYTE_W +: OFF_W];

	always_comb begin
		hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			way_hit[w] = i_tag_valid[w] && (i_tags[w] == cur_addr[ADDR_WIDTH-1 -: TAG_W]);
			if (way_hit[w])
				hit_way = way_t'(w);
		end
	end

	assign any_hit = |way_hit;
	assign adv = !rsp_valid_q || i_rsp_ready; // response slot free at the edge
	assign eval_fire = cur_valid && adv;
	assign miss_now = eval_fire && !any_hit;
	assign s1_done = eval_fire && !replay_q;
	assign o_req_ready = i_lookup_enable && !miss_q && !replay_q && (!s1_valid_q || s1_done);
	assign req_fire = i_req_valid && o_req_ready;

	// index of whatever gets evaluated next cycle
	always_comb begin
		if (replay_q)
			rd_addr = eval_fire ? s1_addr_q : miss_addr_q; // then re-read the held younger one
		else if (i_line_done)
			rd_addr = miss_addr_q;
		else if (req_fire)
			rd_addr = i_req_addr;
		else
			rd_addr = s1_addr_q;
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			s1_valid_q <= 1'b0;
			replay_q <= 1'b0;
			miss_q <= 1'b0;
			rsp_valid_q <= 1'b0;
		end else begin
			if (req_fire)
				s1_valid_q <= 1'b1;
			else if (s1_done)
				s1_valid_q <= 1'b0;
			if (i_line_done)
				replay_q <= 1'b1;
			else if (eval_fire)
				replay_q <= 1'b0;
			if (miss_now)
				miss_q <= 1'b1;
			else if (i_line_done)
				miss_q <= 1'b0;
			if (eval_fire && any_hit)
				rsp_valid_q <= 1'b1;
			else if (i_rsp_ready)
				rsp_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (req_fire)
			s1_addr_q <= i_req_addr;
		if (miss_now) begin
			miss_addr_q <= cur_addr;
			miss_way_q <= i_victim_way;
		end
		if (eval_fire && any_hit)
			rsp_data_q <= i_lines[hit_way][word_off];
	end

	assign o_rd_index = rd_addr[BYTE_W + OFF_W +: IDX_W];
	assign o_rsp_valid = rsp_valid_q;
	assign o_rsp_data = rsp_data_q;
	assign o_access_valid = eval_fire;
	assign o_access_index = cur_addr[BYTE_W + OFF_W +: IDX_W];
	assign o_hit = any_hit;
	assign o_hit_way = hit_way;
	assign o_miss = miss_q;
	assign o_miss_addr = miss_addr_q;
	assign o_miss_way = miss_way_q;

	// a refill into the victim way never duplicates a resident tag
	a_one_hit: assert property (@(posedge i_clk) disable iff (i_rst)
		cur_valid |-> $onehot0(way_hit));

endmodule

`default_nettype wire

// File: verilog/icache_refill.sv
`timescale 1ns/1ps
`default_nettype none

module icache_refill #(
	parameter int SETS = 64,
	parameter int WORDS_PER_LINE = 8,
	localparam int IDX_W = $clog2(SETS),
	localparam int OFF_W = $clog2(WORDS_PER_LINE),
	localparam int LINE_LSB = OFF_W + $clog2(icache_pkg::WORD_BYTES),
	localparam int TAG_W = icache_pkg::ADDR_WIDTH - IDX_W - LINE_LSB
) (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_miss,
	input  icache_pkg::addr_t i_miss_addr,
	input  icache_pkg::way_t  i_miss_way,
	output logic              o_lookup_enable,
	output logic              o_mem_req_valid,
	output icache_pkg::addr_t o_mem_req_addr,
	input  logic              i_mem_req_ready,
	input  logic              i_mem_rsp_valid,
	input  icache_pkg::word_t i_mem_rsp_data,
	input  logic              i_mem_rsp_last,
	output logic              o_tag_wr_en,
	output icache_pkg::way_t  o_tag_wr_way,
	output logic [IDX_W-1:0]  o_tag_wr_index,
	output logic              o_tag_wr_valid,
	output logic [TAG_W-1:0]  o_tag_wr_tag,
	output logic              o_data_wr_en,
	output icache_pkg::way_t  o_data_wr_way,
	output logic [IDX_W-1:0]  o_data_wr_index,
	output logic [OFF_W-1:0]  o_data_wr_offset,
	output icache_pkg::word_t o_data_wr_data,
	output logic              o_line_done
);
	import icache_pkg::*;

	icache_state_e state_q;
	logic [IDX_W-1:0] sweep_cnt_q;
	logic [OFF_W-1:0] beat_cnt_q;
	addr_t line_addr_q;
	way_t way_q;
	logic beat;

	assign beat = (state_q == RECEIVING) && i_mem_rsp_valid;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state_q <= INVALIDATING;
			sweep_cnt_q <= '0;
			beat_cnt_q <= '0;
		end else begin
			case (state_q)
				INVALIDATING: begin
					sweep_cnt_q <= sweep_cnt_q + 1'b1; // one set per cycle
					if (sweep_cnt_q == IDX_W'(SETS - 1))
						state_q <= IDLE;
				end
				IDLE: begin
					if (i_miss)
						state_q <= MEM_REQUEST;
				end
				MEM_REQUEST: begin
					if (i_mem_req_ready) begin
						state_q <= RECEIVING;
						beat_cnt_q <= '0;
					end
				end
				RECEIVING: begin
					if (i_mem_rsp_valid) begin
						beat_cnt_q <= beat_cnt_q + 1'b1;
						if (i_mem_rsp_last)
							state_q <= LINE_DONE;
					end
				end
				LINE_DONE: state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state_q == IDLE && i_miss) begin
			line_addr_q <= {i_miss_addr[ADDR_WIDTH-1:LINE_LSB], {LINE_LSB{1'b0}}};
			way_q <= i_miss_way;
		end
	end

	assign o_lookup_enable = state_q == IDLE;
	assign o_mem_req_valid = state_q == MEM_REQUEST;
	assign o_mem_req_addr = line_addr_q;

	// tag goes in last, after every word of the line is stored
	assign o_tag_wr_en = (state_q == INVALIDATING) || (state_q == LINE_DONE);
	assign o_tag_wr_way = way_q;
	assign o_tag_wr_index = (state_q == INVALIDATING) ? sweep_cnt_q
		: line_addr_q[LINE_LSB +: IDX_W];
	assign o_tag_wr_valid = state_q == LINE_DONE;
	assign o_tag_wr_tag = line_addr_q[ADDR_WIDTH-1 -: TAG_W];

	assign o_data_wr_en = beat;
	assign o_data_wr_way = way_q;
	assign o_data_wr_index = line_addr_q[LINE_LSB +: IDX_W];
	assign o_data_wr_offset = beat_cnt_q; // words arrive from word 0 upward
	assign o_data_wr_data = i_mem_rsp_data;
	assign o_line_done = state_q == LINE_DONE;

	// memory must flag last on exactly the final word of the line
	a_last_beat: assert property (@(posedge i_clk) disable iff (i_rst)
		beat |-> (i_mem_rsp_last == (beat_cnt_q == OFF_W'(WORDS_PER_LINE - 1))));

endmodule

`default_nettype wire

// File: verilog/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
	parameter int SETS = 64,
	parameter int WORDS_PER_LINE = 8
) (
	input  logic               i_clk,
	input  logic               i_rst,
	input  logic               i_req_valid,
	input  icache_pkg::addr_t  i_req_addr,
	output logic               o_req_ready,
	output logic               o_rsp_valid,
	output icache_pkg::word_t  o_rsp_data,
	input  logic               i_rsp_ready,
	output logic               o_mem_req_valid,
	output icache_pkg::addr_t  o_mem_req_addr,
	input  logic               i_mem_req_ready,
	input  logic               i_mem_rsp_valid,
	input  icache_pkg::word_t  i_mem_rsp_data,
	input  logic               i_mem_rsp_last
);
	import icache_pkg::*;

	localparam int IDX_W = $clog2(SETS);
	localparam int OFF_W = $clog2(WORDS_PER_LINE);
	localparam int TAG_W = ADDR_WIDTH - IDX_W - OFF_W - $clog2(WORD_BYTES);

	logic [IDX_W-1:0] rd_index;
	logic [NUM_WAYS-1:0] tag_valid;
	logic [NUM_WAYS-1:0][TAG_W-1:0] tags;
	word_t [NUM_WAYS-1:0][WORDS_PER_LINE-1:0] lines;

	logic access_valid;
	logic [IDX_W-1:0] access_index;
	logic hit;
	way_t hit_way;
	way_t victim_way;

	logic miss;
	addr_t miss_addr;
	way_t miss_way;
	logic line_done;
	logic lookup_enable;

	logic tag_wr_en;
	way_t tag_wr_way;
	logic [IDX_W-1:0] tag_wr_index;
	logic tag_wr_valid;
	logic [TAG_W-1:0] tag_wr_tag;
	logic data_wr_en;
	way_t data_wr_way;
	logic [IDX_W-1:0] data_wr_index;
	logic [OFF_W-1:0] data_wr_offset;
	word_t data_wr_data;

	icache_lookup #(
		.SETS           (SETS),
		.WORDS_PER_LINE (WORDS_PER_LINE)
	) u_lookup (
		.i_clk           (i_clk),
		.i_rst           (i_rst),
		.i_req_valid     (i_req_valid),
		.i_req_addr      (i_req_addr),
		.o_req_ready     (o_req_ready),
		.o_rsp_valid     (o_rsp_valid),
		.o_rsp_data      (o_rsp_data),
		.i_rsp_ready     (i_rsp_ready),
		.i_lookup_enable (lookup_enable),
		.o_rd_index      (rd_index),
		.i_tag_valid     (tag_valid),
		.i_tags          (tags),
		.i_lines         (lines),
		.o_access_valid  (access_valid),
		.o_access_index  (access_index),
		.o_hit           (hit),
		.o_hit_way       (hit_way),
		.i_victim_way    (victim_way),
		.o_miss          (miss),
		.o_miss_addr     (miss_addr),
		.o_miss_way      (miss_way),
		.i_line_done     (line_done)
	);

	icache_tag_array #(
		.SETS           (SETS),
		.WORDS_PER_LINE (WORDS_PER_LINE)
	) u_tag_array (
		.i_clk      (i_clk),
		.i_rd_index (rd_index),
		.i_wr_en    (tag_wr_en),
		.i_wr_way   (tag_wr_way),
		.i_wr_index (tag_wr_index),
		.i_wr_valid (tag_wr_valid),
		.i_wr_tag   (tag_wr_tag),
		.o_rd_valid (tag_valid),
		.o_rd_tags  (tags)
	);

	icache_data_array #(
		.SETS           (SETS),
		.WORDS_PER_LINE (WORDS_PER_LINE)
	) u_data_array (
		.i_clk       (i_clk),
		.i_rd_index  (rd_index),
		.i_wr_en     (data_wr_en),
		.i_wr_way    (data_wr_way),
		.i_wr_index  (data_wr_index),
		.i_wr_offset (data_wr_offset),
		.i_wr_data   (data_wr_data),
		.o_rd_lines  (lines)
	);

	icache_plru #(
		.SETS (SETS)
	) u_plru (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_access_valid (access_valid),
		.i_access_index (access_index),
		.i_hit          (hit),
		.i_hit_way      (hit_way),
		.o_victim_way   (victim_way)
	);

	icache_refill #(
		.SETS           (SETS),
		.WORDS_PER_LINE (WORDS_PER_LINE)
	) u_refill (
		.i_clk            (i_clk),
		.i_rst            (i_rst),
		.i_miss           (miss),
		.i_miss_addr      (miss_addr),
		.i_miss_way       (miss_way),
		.o_lookup_enable  (lookup_enable),
		.o_mem_req_valid  (o_mem_req_valid),
		.o_mem_req_addr   (o_mem_req_addr),
		.i_mem_req_ready  (i_mem_req_ready),
		.i_mem_rsp_valid  (i_mem_rsp_valid),
		.i_mem_rsp_data   (i_mem_rsp_data),
		.i_mem_rsp_last   (i_mem_rsp_last),
		.o_tag_wr_en      (tag_wr_en),
		.o_tag_wr_way     (tag_wr_way),
		.o_tag_wr_index   (tag_wr_index),
		.o_tag_wr_valid   (tag_wr_valid),
		.o_tag_wr_tag     (tag_wr_tag),
		.o_data_wr_en     (data_wr_en),
		.o_data_wr_way    (data_wr_way),
		.o_data_wr_index  (data_wr_index),
		.o_data_wr_offset (data_wr_offset),
		.o_data_wr_data   (data_wr_data),
		.o_line_done      (line_done)
	);

endmodule

`default_nettype wire

// File: tb/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model #(
	parameter int WORDS_PER_LINE = 8
) (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_req_valid,
	output logic              o_req_ready,
	input  icache_pkg::addr_t i_req_addr,
	input  logic [3:0]        i_gap,
	output logic              o_rsp_valid,
	output icache_pkg::word_t o_rsp_data,
	output logic              o_rsp_last,
	output logic [15:0]       o_req_count
);
	import icache_pkg::*;

	logic busy_q;
	addr_t addr_q;
	int beat_q;
	logic [3:0] wait_q;

	// upper half inverted so neighbouring words never look alike
	function automatic word_t mem_word(input addr_t a);
		return {~a[31:16], a[15:0]};
	endfunction

	assign o_req_ready = !busy_q;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			busy_q <= 1'b0;
			o_rsp_valid <= 1'b0;
			o_rsp_last <= 1'b0;
			o_req_count <= '0;
		end else begin
			o_rsp_valid <= 1'b0;
			o_rsp_last <= 1'b0;
			if (!busy_q) begin
				if (i_req_valid) begin
					busy_q <= 1'b1;
					addr_q <= i_req_addr;
					beat_q <= 0;
					wait_q <= i_gap; // idle cycles before the first beat too
					o_req_count <= o_req_count + 1'b1;
				end
			end else if (wait_q != 0) begin
				wait_q <= wait_q - 1'b1;
			end else begin
				o_rsp_valid <= 1'b1;
				o_rsp_data <= mem_word(addr_q + beat_q * WORD_BYTES);
				o_rsp_last <= beat_q == WORDS_PER_LINE - 1;
				beat_q <= beat_q + 1;
				wait_q <= i_gap;
				if (beat_q == WORDS_PER_LINE - 1)
					busy_q <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache;
	import icache_pkg::*;

	localparam int SETS = 64;
	localparam int WORDS_PER_LINE = 8;
	localparam int LINE_BYTES = WORDS_PER_LINE * WORD_BYTES;
	localparam int TIMEOUT = 400;

	logic clk = 1'b0;
	logic rst;
	logic req_valid;
	addr_t req_addr;
	logic req_ready;
	logic rsp_valid;
	word_t rsp_data;
	logic rsp_ready;
	logic mem_req_valid;
	addr_t mem_req_addr;
	logic mem_req_ready;
	logic mem_rsp_valid;
	word_t mem_rsp_data;
	logic mem_rsp_last;
	logic [3:0] mem_gap;
	logic [15:0] mem_req_count;

	int cyc = 0;
	logic [15:0] lfsr = 16'd84;
	int n_mismatch = 0;
	int n_timeout = 0;
	int n_other = 0;
	int exp_reqs = 0;

	word_t exp_data_q[$];
	int req_cyc_q[$];
	word_t got_data_q[$];
	int got_cyc_q[$];
	addr_t exp_mem_q[$];
	addr_t got_mem_q[$];

	// reference cache, line number per way plus tree bits per set
	bit m_valid [SETS][NUM_WAYS];
	bit [31:0] m_line [SETS][NUM_WAYS];
	bit [2:0] m_plru [SETS];

	always #4 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	icache_top #(
		.SETS           (SETS),
		.WORDS_PER_LINE (WORDS_PER_LINE)
	) u_icache_top (
		.i_clk           (clk),
		.i_rst           (rst),
		.i_req_valid     (req_valid),
		.i_req_addr      (req_addr),
		.o_req_ready     (req_ready),
		.o_rsp_valid     (rsp_valid),
		.o_rsp_data      (rsp_data),
		.i_rsp_ready     (rsp_ready),
		.o_mem_req_valid (mem_req_valid),
		.o_mem_req_addr  (mem_req_addr),
		.i_mem_req_ready (mem_req_ready),
		.i_mem_rsp_valid (mem_rsp_valid),
		.i_mem_rsp_data  (mem_rsp_data),
		.i_mem_rsp_last  (mem_rsp_last)
	);

	tb_mem_model #(
		.WORDS_PER_LINE (WORDS_PER_LINE)
	) u_mem_model (
		.i_clk       (clk),
		.i_rst       (rst),
		.i_req_valid (mem_req_valid),
		.o_req_ready (mem_req_ready),
		.i_req_addr  (mem_req_addr),
		.i_gap       (mem_gap),
		.o_rsp_valid (mem_rsp_valid),
		.o_rsp_data  (mem_rsp_data),
		.o_rsp_last  (mem_rsp_last),
		.o_req_count (mem_req_count)
	);

	// record every response and line request with its edge number
	always @(posedge clk) begin
		if (rsp_valid && rsp_ready) begin
			got_data_q.push_back(rsp_data);
			got_cyc_q.push_back(cyc);
		end
		if (mem_req_valid && mem_req_ready)
			got_mem_q.push_back(mem_req_addr);
	end

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]}; // x^16+x^14+x^13+x^11+1
			v = (v << 1) | lfsr[0];
		end
		return v;
	endfunction

	function automatic word_t expected_word(input addr_t a);
		return {~a[31:16], a[15:0]};
	endfunction

	function automatic void model_access(input addr_t a);
		bit [31:0] line;
		int set;
		int way;
		bit hit;
		line = a / LINE_BYTES;
		set = line % SETS;
		hit = 1'b0;
		way = 0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (m_valid[set][w] && m_line[set][w] == line) begin
				hit = 1'b1;
				way = w;
			end
		end
		if (!hit) begin
			if (m_plru[set][2])
				way = m_plru[set][0] ? 0 : 1;
			else
				way = m_plru[set][1] ? 2 : 3;
			m_valid[set][way] = 1'b1;
			m_line[set][way] = line;
			exp_reqs++;
			exp_mem_q.push_back(line * LINE_BYTES);
		end
		m_plru[set][2] = way >= 2; // root now points at the other pair
		if (way >= 2)
			m_plru[set][1] = way == 3;
		else
			m_plru[set][0] = way == 1;
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			n_mismatch++;
		end
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		if (exp !== act) begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			n_mismatch++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
			n_mismatch++;
		end
	endtask

	task automatic send_req(input addr_t a);
		int t;
		t = 0;
		req_valid = 1'b1;
		req_addr = a;
		@(posedge clk);
		while (!req_ready && t < TIMEOUT) begin
			@(posedge clk);
			t++;
		end
		if (req_ready) begin
			req_cyc_q.push_back(cyc);
			exp_data_q.push_back(expected_word(a));
			model_access(a);
		end else begin
			$display("fetch request for %h was never accepted", a);
			n_timeout++;
		end
		#1;
		req_valid = 1'b0;
	endtask

	task automatic drain(input string name, input bit lat_check);
		int t;
		int lat;
		t = 0;
		while (got_data_q.size() < exp_data_q.size() && t < TIMEOUT) begin
			@(posedge clk);
			#1;
			t++;
		end
		if (got_data_q.size() < exp_data_q.size()) begin
			$display("%s: only %0d of %0d responses arrived before the timeout", name,
				got_data_q.size(), exp_data_q.size());
			n_timeout++;
		end
		while (exp_data_q.size() > 0 && got_data_q.size() > 0) begin
			check_word(name, exp_data_q.pop_front(), got_data_q.pop_front());
			lat = got_cyc_q.pop_front() - req_cyc_q.pop_front();
			if (lat_check)
				check_count({name, " latency"}, 2, lat);
		end
		if (got_data_q.size() > 0) begin
			$display("%s: a response arrived that no request asked for", name);
			n_other++;
		end
		exp_data_q.delete();
		req_cyc_q.delete();
		got_data_q.delete();
		got_cyc_q.delete();
		while (exp_mem_q.size() > 0 && got_mem_q.size() > 0)
			check_addr({name, " line address"}, exp_mem_q.pop_front(), got_mem_q.pop_front());
		exp_mem_q.delete();
		got_mem_q.delete();
		check_count({name, " memory requests"}, exp_reqs, int'(mem_req_count));
	endtask

	task automatic sweep_after_reset();
		int low;
		low = 0;
		@(posedge clk);
		while (!req_ready && low < SETS + 20) begin
			if (rsp_valid || mem_req_valid) begin
				$display("reset_sweep: response or memory request raised during the sweep");
				n_other++;
			end
			low++;
			@(posedge clk);
		end
		if (!req_ready) begin
			$display("reset_sweep: request port never became ready after reset");
			n_timeout++;
		end
		check_count("reset_sweep ready low cycles", SETS, low);
		#1;
		send_req(32'h0000_1234);
		drain("first_fetch", 1'b0);
	endtask

	task automatic stream_filled_line();
		addr_t base;
		base = 32'h0002_0040;
		send_req(base);
		drain("line_fill", 1'b0);
		for (int k = 0; k < WORDS_PER_LINE; k++)
			send_req(base + k * WORD_BYTES);
		drain("line_stream", 1'b1);
	endtask

	task automatic replace_in_one_set();
		addr_t lines [5];
		int order [4];
		for (int i = 0; i < 5; i++)
			lines[i] = 32'h0004_0000 + i * 32'h800 + 5 * LINE_BYTES + 8; // all in set 5
		order = '{0, 2, 3, 1};
		for (int i = 0; i < 4; i++) begin
			send_req(lines[i]);
			drain($sformatf("replace_fill_l%0d", i), 1'b0);
		end
		send_req(lines[0]);
		drain("replace_touch_l0", 1'b0);
		send_req(lines[4]);
		drain("replace_fetch_l4", 1'b0);
		for (int i = 0; i < 4; i++) begin
			send_req(lines[order[i]]);
			drain($sformatf("replace_reread_l%0d", order[i]), 1'b0);
		end
	endtask

	task automatic hold_under_backpressure();
		addr_t a0;
		addr_t a1;
		a0 = 32'h0002_0048;
		a1 = 32'h0002_0054;
		rsp_ready = 1'b0;
		send_req(a0);
		send_req(a1);
		for (int i = 0; i < 6; i++) begin
			@(posedge clk);
			if (!rsp_valid) begin
				$display("backpressure: waiting response was dropped");
				n_other++;
			end
			check_word("backpressure hold", expected_word(a0), rsp_data);
			if (req_ready) begin
				$display("backpressure: request port ready while both stages are full");
				n_other++;
			end
		end
		#1;
		rsp_ready = 1'b1;
		drain("backpressure", 1'b0);
	endtask

	task automatic miss_with_random_gaps();
		addr_t a;
		addr_t b;
		for (int i = 0; i < 6; i++) begin
			mem_gap = 4'(rand_bits(2));
			a = addr_t'(rand_bits(30)) << 2;
			b = addr_t'(rand_bits(30)) << 2;
			send_req(a);
			send_req(b); // held in stage 1 behind the miss
			drain($sformatf("random_miss_%0d", i), 1'b0);
		end
	endtask

	initial begin
		rst = 1'b1;
		req_valid = 1'b0;
		req_addr = '0;
		rsp_ready = 1'b1;
		mem_gap = '0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		sweep_after_reset();
		stream_filled_line();
		replace_in_one_set();
		hold_under_backpressure();
		miss_with_random_gaps();
		repeat (4) @(posedge clk);
		$display("errors: %0d mismatches, %0d timeouts, %0d other failures",
			n_mismatch, n_timeout, n_other);
		if (n_mismatch + n_timeout + n_other == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
verilog/icache_pkg.sv
verilog/icache_tag_array.sv
verilog/icache_data_array.sv
verilog/icache_plru.sv
verilog/icache_lookup.sv
verilog/icache_refill.sv
verilog/icache_top.sv
tb/tb_mem_model.sv
tb/tb_icache.sv

// File: Bender.yml
package:
  name: icache

sources:
  - files:
      - verilog/icache_pkg.sv
      - verilog/icache_tag_array.sv
      - verilog/icache_data_array.sv
      - verilog/icache_plru.sv
      - verilog/icache_lookup.sv
      - verilog/icache_refill.sv
      - verilog/icache_top.sv
  - target: test
    files:
      - tb/tb_mem_model.sv
      - tb/tb_icache.sv
